/* Bender.yml */
package:
  name: x25519_mult

export_include_dirs:
  - .

sources:
  - x25519_pkg.sv
  - x25519_mult_ctrl.sv
  - x25519_limb_counter.sv
  - x25519_mult_pass.sv
  - x25519_squeeze.sv
  - x25519_mult.sv
  - target: test
    files:
      - x25519_mult_tb.sv

/* flist.f */
+incdir+.
x25519_pkg.sv
x25519_mult_ctrl.sv
x25519_limb_counter.sv
x25519_mult_pass.sv
x25519_squeeze.sv
x25519_mult.sv
x25519_mult_tb.sv

/* x25519_limb_counter.sv */
`timescale 1ns/1ps
`include "x25519_params.svh"

module x25519_limb_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       count_en,           // Advance one term
	input  logic       clear,              // Back to column 0, term 0
	output logic [4:0] col_idx,            // Output limb being built
	output logic [4:0] term_idx,           // Limb of a in use
	output logic       term_last,
	output logic       col_last
);

	localparam logic [4:0] IDX_LAST = 5'(`X25519_NLIMBS - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_idx  <= '0;
			term_idx <= '0;
		end else if (clear) begin
			col_idx  <= '0;
			term_idx <= '0;
		end else if (count_en) begin
			term_idx <= term_idx + 5'd1;   // Wraps to 0 after 31
			if (term_last) begin
				col_idx <= col_idx + 5'd1; // Next column on term wrap
			end
		end
	end

	// Decoded from current indices
	assign term_last = (term_idx == IDX_LAST);
	assign col_last  = (col_idx == IDX_LAST);

endmodule

/* x25519_mult.sv */
`timescale 1ns/1ps

module x25519_mult (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,    // Single-cycle strobe
	input  x25519_pkg::mult_operands_t operands, // Sampled with start
	output logic                       busy,
	output logic                       done,     // Single-cycle strobe
	output x25519_pkg::fe_t            result
);

	logic                capture;
	logic                count_en;
	logic [4:0]          col_idx;
	logic [4:0]          term_idx;
	logic                term_last;
	logic                col_last;
	x25519_pkg::column_t column;
	logic                col_valid;
	logic                sq_done;

	x25519_mult_ctrl i_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.col_last  (col_last),
		.term_last (term_last),
		.sq_done   (sq_done),
		.capture   (capture),
		.count_en  (count_en),
		.busy      (busy),
		.done      (done)
	);

	// Clear shares the capture pulse
	x25519_limb_counter i_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.count_en  (count_en),
		.clear     (capture),
		.col_idx   (col_idx),
		.term_idx  (term_idx),
		.term_last (term_last),
		.col_last  (col_last)
	);

	x25519_mult_pass i_pass (
		.clk       (clk),
		.rst_n     (rst_n),
		.capture   (capture),
		.operands  (operands),
		.count_en  (count_en),
		.col_idx   (col_idx),
		.term_idx  (term_idx),
		.term_last (term_last),
		.column    (column),
		.col_valid (col_valid)
	);

	x25519_squeeze i_squeeze (
		.clk       (clk),
		.rst_n     (rst_n),
		.column    (column),
		.col_valid (col_valid),
		.result    (result),
		.sq_done   (sq_done)
	);

endmodule

/* x25519_mult_ctrl.sv */
`timescale 1ns/1ps

module x25519_mult_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,                    // Single-cycle request
	input  logic col_last,                 // Counter on final column
	input  logic term_last,                // Counter on final term of a column
	input  logic sq_done,                  // Squeeze has the reduced value
	output logic capture,                  // Load operands, clear counter
	output logic count_en,                 // Step the column passes
	output logic busy,
	output logic done
);

	x25519_pkg::ctrl_state_t state;
	x25519_pkg::ctrl_state_t state_nxt;

	always_comb begin
		state_nxt = state;                 // Hold by default
		case (state)
			x25519_pkg::IDLE: begin
				if (start) begin
					state_nxt = x25519_pkg::CAPTURE;
				end
			end
			x25519_pkg::CAPTURE: begin
				state_nxt = x25519_pkg::PASS;  // Operands valid next cycle
			end
			x25519_pkg::PASS: begin
				if (term_last && col_last) begin
					state_nxt = x25519_pkg::DRAIN; // Last limb pair just issued
				end
			end
			x25519_pkg::DRAIN: begin
				if (sq_done) begin
					state_nxt = x25519_pkg::DONE;
				end
			end
			x25519_pkg::DONE: begin
				state_nxt = x25519_pkg::IDLE;
			end
			default: begin
				state_nxt = x25519_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= x25519_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Operands load on the accepted start edge
	assign capture  = (state == x25519_pkg::IDLE) && start;

	// Moore outputs, all low in IDLE
	assign count_en = (state == x25519_pkg::PASS);
	assign done     = (state == x25519_pkg::DONE);

	// Start is only looked at in IDLE, so a start while busy drops
	assign busy = (state == x25519_pkg::CAPTURE) ||
		(state == x25519_pkg::PASS) ||
		(state == x25519_pkg::DRAIN);

endmodule

/* x25519_mult_pass.sv */
`timescale 1ns/1ps
`include "x25519_params.svh"

module x25519_mult_pass (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       capture,   // Load operand registers
	input  x25519_pkg::mult_operands_t operands,
	input  logic                       count_en,  // One limb pair this cycle
	input  logic [4:0]                 col_idx,
	input  logic [4:0]                 term_idx,
	input  logic                       term_last, // Column complete after this term
	output x25519_pkg::column_t        column,
	output logic                       col_valid
);

	localparam int LIMB_W = `X25519_LIMB_W;
	localparam int COL_W  = `X25519_COL_W;

	x25519_pkg::mult_operands_t opnd_q;   // Held for the whole run
	logic [4:0]                 b_idx;
	logic                       wrap;
	logic [2*LIMB_W-1:0]        prod;
	logic [COL_W-1:0]           term;
	logic [COL_W-1:0]           acc;

	always_ff @(posedge clk) begin
		if (capture) begin
			opnd_q <= operands;
		end
	end

	always_comb begin
		b_idx = col_idx - term_idx;        // Mod 32 by width
		wrap  = (term_idx > col_idx);      // Term lands above 2^256
		prod  = opnd_q.a[term_idx] * opnd_q.b[b_idx];
		term  = {{(COL_W-2*LIMB_W){1'b0}}, prod};
		if (wrap) begin
			term = term * `X25519_FOLD_MUL; // 2^256 folds to 38
		end
	end

	// Accumulator and strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc       <= '0;
			col_valid <= 1'b0;
		end else begin
			col_valid <= count_en && term_last;
			if (capture) begin
				acc <= '0;
			end else if (count_en) begin
				acc <= term_last ? '0 : acc + term; // Restart for next column
			end
		end
	end

	// Column payload, valid with col_valid
	always_ff @(posedge clk) begin
		if (count_en && term_last) begin
			column.idx <= col_idx;
			column.sum <= acc + term;      // Include the final term
		end
	end

endmodule

/* x25519_mult_tb.sv */
`timescale 1ns/1ps

module x25519_mult_tb;

	localparam int CLK_HALF   = 4;                // 8 ns period
	localparam int NTESTS     = 40;
	localparam int RUN_CYCLES = 1200;             // Worst-case run plus slack
	localparam int TIMEOUT_NS = NTESTS * RUN_CYCLES * 2 * CLK_HALF + 20000;

	// 2^255 - 19
	localparam logic [255:0] P_MOD = (256'd1 << 255) - 256'd19;

	logic                       clk;
	logic                       rst_n;
	logic                       start;
	x25519_pkg::mult_operands_t operands;
	logic                       busy;
	logic                       done;
	x25519_pkg::fe_t            result;

	logic [31:0] rng_state;                      // xorshift32 state
	string       cur_test;
	int          errors;
	int          checks;
	int          starts_accepted;                // Starts seen in IDLE
	int          dones_seen;

	x25519_mult i_x25519_mult (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.operands (operands),
		.busy     (busy),
		.done     (done),
		.result   (result)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Eight draws per field element, low word first
	task automatic random_fe(output logic [255:0] v);
		for (int i = 0; i < 8; i++) begin
			rng_state = xorshift32(rng_state);
			v[i*32 +: 32] = rng_state;
		end
	endtask

	// Full 512-bit product, then canonical remainder
	function automatic logic [255:0] mod_mul(input logic [255:0] a, input logic [255:0] b);
		logic [511:0] prod;
		logic [511:0] rem;
		prod = {256'd0, a} * {256'd0, b};
		rem  = prod % {256'd0, P_MOD};
		return rem[255:0];
	endfunction

	task automatic check_fe(input string what, input logic [255:0] exp, input logic [255:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h actual %h", what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected %b actual %b", what, exp, act);
		end
	endtask

	// Sampled on the falling edge, away from the drive and update edges
	task automatic wait_done(output bit seen);
		int cycles;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < RUN_CYCLES) begin
			@(negedge clk);
			cycles++;
			seen = done;
		end
		if (!seen) begin
			errors++;
			$display("%s: no done within %0d cycles, controller in %s", cur_test,
				RUN_CYCLES, i_x25519_mult.i_ctrl.state.name());
		end
	endtask

	task automatic run_product(input string name, input logic [255:0] a,
		input logic [255:0] b, input bit busy_start);
		logic [255:0] exp;
		logic [255:0] junk_a;
		logic [255:0] junk_b;
		int           dones_before;
		bit           seen;
		cur_test     = name;
		exp          = mod_mul(a, b);
		dones_before = dones_seen;
		@(posedge clk);
		#1;
		start      = 1'b1;
		operands.a = a;
		operands.b = b;
		@(posedge clk);
		#1;
		start = 1'b0;
		random_fe(junk_a);
		random_fe(junk_b);
		operands.a = junk_a;                     // Captured with start, inputs now free
		operands.b = junk_b;
		if (busy_start) begin
			repeat (100) @(posedge clk);
			#1;
			start      = 1'b1;                   // Mid-run request, must drop
			operands.a = junk_b;
			operands.b = ~a;
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		wait_done(seen);
		if (seen) begin
			check_fe(name, exp, result);
		end
		repeat (4) @(posedge clk);               // Gap where a stray done would show
		checks++;
		assert (dones_seen == dones_before + 1) else begin
			errors++;
			$display("CHECK FAILED %s: dones expected %0d actual %0d", name,
				dones_before + 1, dones_seen);
		end
	endtask

	// Done must pair with one accepted start
	always @(negedge clk) begin
		if (rst_n) begin
			if (start && !busy && !done) begin
				starts_accepted++;
			end
			if (done) begin
				dones_seen++;
				assert (dones_seen == starts_accepted) else begin
					errors++;
					$display("CHECK FAILED %s: done count expected %0d actual %0d",
						cur_test, starts_accepted, dones_seen);
				end
			end
		end
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done) else begin
		errors++;
		$display("CHECK FAILED %s: done after done expected 0 actual 1", cur_test);
	end

	done_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (!busy && $past(busy))) else begin
		errors++;
		$display("Handshake error in %s: done without busy falling", cur_test);
	end

	busy_fall_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> done) else begin
		errors++;
		$display("Handshake error in %s: busy fell without done", cur_test);
	end

	start_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy && !done) |=> busy) else begin
		errors++;
		$display("Handshake error in %s: busy not high after start", cur_test);
	end

	initial begin
		logic [255:0] x;
		logic [255:0] y;
		clk             = 1'b0;
		rst_n           = 1'b0;
		start           = 1'b0;
		operands        = '0;
		rng_state       = 32'h6c89d0ba;
		errors          = 0;
		checks          = 0;
		starts_accepted = 0;
		dones_seen      = 0;
		cur_test        = "reset";
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_bit("reset busy", 1'b0, busy);
			check_bit("reset done", 1'b0, done);
		end

		random_fe(x);
		run_product("zero times x", 256'd0, x, 1'b0);
		run_product("one times x", 256'd1, x, 1'b0);
		run_product("p-1 squared", P_MOD - 256'd1, P_MOD - 256'd1, 1'b0);
		run_product("all ones squared", {256{1'b1}}, {256{1'b1}}, 1'b0);

		for (int i = 0; i < 32; i++) begin
			random_fe(x);
			random_fe(y);
			run_product($sformatf("random %0d", i), x, y, 1'b0);
		end

		random_fe(x);
		random_fe(y);
		run_product("start while busy", x, y, 1'b1);

		random_fe(x);
		random_fe(y);
		run_product("operand capture", x, y, 1'b0);

		$display("Errors: %0d in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Bound on the whole run
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns in test %s", TIMEOUT_NS, cur_test);
		$display("Test failures found");
		$finish;
	end

endmodule

/* x25519_params.svh */
`ifndef X25519_PARAMS_SVH
`define X25519_PARAMS_SVH

// Field element layout, radix 2^8
`define X25519_LIMB_W 8

// 32 limbs give 256 bits per operand
`define X25519_NLIMBS 32

// Width of one column sum
// 32 terms of 255 * 255 * 38 stay under 2^27
`define X25519_COL_W 32

// 2^256 mod (2^255 - 19)
// Weight for wrapped partial products and top carries
`define X25519_FOLD_MUL 38

`endif

/* x25519_pkg.sv */
`include "x25519_params.svh"

package x25519_pkg;

	// One field element, limb 0 in the low byte
	typedef logic [`X25519_NLIMBS-1:0][`X25519_LIMB_W-1:0] fe_t;

	// Multiplier inputs, captured together at start
	typedef struct packed {
		fe_t a;                            // Left operand
		fe_t b;                            // Right operand
	} mult_operands_t;

	// One finished column from the multiply pass
	typedef struct packed {
		logic [4:0]               idx;     // Output limb this sum belongs to
		logic [`X25519_COL_W-1:0] sum;     // Weighted sum of all terms
	} column_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,                              // Waiting for start
		CAPTURE,                           // Operand load, counter clear
		PASS,                              // One limb pair per cycle
		DRAIN,                             // Squeeze finishing alone
		DONE                               // Single-cycle done strobe
	} ctrl_state_t;

endpackage

/* x25519_squeeze.sv */
`timescale 1ns/1ps
`include "x25519_params.svh"

module x25519_squeeze (
	input  logic                clk,
	input  logic                rst_n,
	input  x25519_pkg::column_t column,
	input  logic                col_valid,    // One column, no back-pressure
	output x25519_pkg::fe_t     result,       // Canonical product
	output logic                sq_done
);

	localparam int LIMB_W = `X25519_LIMB_W;
	localparam int COL_W  = `X25519_COL_W;
	localparam int FE_W   = `X25519_LIMB_W * `X25519_NLIMBS;

	// 2^255 - 19, low byte 0xed
	localparam logic [FE_W-1:0] P = {1'b0, {(FE_W-6){1'b1}}, 5'b01101};

	typedef enum logic [1:0] {
		SQ_COLLECT,                        // Taking columns from the pass
		SQ_FOLD,                           // Top carry sweeps through limbs
		SQ_SUB                             // Two compare-subtract cycles
	} sq_phase_t;

	sq_phase_t        phase;
	x25519_pkg::fe_t  work;                // Value under reduction
	logic [COL_W-1:0] carry;               // Running carry, also fold value
	logic [4:0]       fold_idx;            // Limb touched by the sweep
	logic             sub_second;          // Second subtract cycle
	logic [COL_W-1:0] col_sum;
	logic [COL_W-1:0] col_carry;
	logic [COL_W-1:0] fold_sum;
	logic [COL_W-1:0] fold_carry;
	logic [FE_W-1:0]  work_flat;
	logic [FE_W-1:0]  work_red;

	always_comb begin
		col_sum    = column.sum + carry;   // Carry left clear by the last run
		col_carry  = col_sum >> LIMB_W;
		fold_sum   = {{(COL_W-LIMB_W){1'b0}}, work[fold_idx]} + carry;
		fold_carry = fold_sum >> LIMB_W;
		work_flat  = work;
		work_red   = (work_flat >= P) ? work_flat - P : work_flat; // Conditional subtract
	end

	// Working limbs
	always_ff @(posedge clk) begin
		if (col_valid) begin
			work[column.idx] <= col_sum[LIMB_W-1:0]; // Low byte is final for now
		end else if (phase == SQ_FOLD) begin
			work[fold_idx] <= fold_sum[LIMB_W-1:0];
		end else if (phase == SQ_SUB) begin
			work <= work_red;
		end
	end

	// Sequencing of the three phases
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase      <= SQ_COLLECT;
			carry      <= '0;
			fold_idx   <= '0;
			sub_second <= 1'b0;
			sq_done    <= 1'b0;
		end else begin
			sq_done <= 1'b0;
			case (phase)
				SQ_COLLECT: begin
					if (col_valid) begin
						if (column.idx == 5'd31) begin
							carry    <= col_carry * `X25519_FOLD_MUL; // Bits above 2^256
							fold_idx <= '0;
							phase    <= SQ_FOLD;
						end else begin
							carry <= col_carry;
						end
					end
				end
				SQ_FOLD: begin
					fold_idx <= fold_idx + 5'd1;
					if (fold_idx == 5'd31) begin
						if (fold_carry != '0) begin
							carry <= fold_carry * `X25519_FOLD_MUL; // Another sweep
						end else begin
							carry      <= '0;
							sub_second <= 1'b0;
							phase      <= SQ_SUB;  // Value now below 2^256
						end
					end else begin
						carry <= fold_carry;
					end
				end
				SQ_SUB: begin
					sub_second <= 1'b1;
					if (sub_second) begin
						sq_done <= 1'b1;           // Below p after two subtracts
						phase   <= SQ_COLLECT;
					end
				end
				default: begin
					phase <= SQ_COLLECT;
				end
			endcase
		end
	end

	// Output holds until the next run finishes
	always_ff @(posedge clk) begin
		if (sq_done) begin
			result <= work;
		end
	end

endmodule
